//--- Bender.yml
package:
  name: exe_core

sources:
  - verilog/exe_isa_pkg.sv
  - verilog/exe_bus_pkg.sv
  - verilog/dispatch_unit.sv
  - verilog/reservation_station.sv
  - verilog/sc_alu.sv
  - verilog/mc_alu.sv
  - verilog/wb_arbiter.sv
  - verilog/exe_core.sv
  - target: simulation
    files:
      - verification/exe_core_sva.sv
      - verification/exe_core_tb.sv

//--- sources.f
verilog/exe_isa_pkg.sv
verilog/exe_bus_pkg.sv
verilog/dispatch_unit.sv
verilog/reservation_station.sv
verilog/sc_alu.sv
verilog/mc_alu.sv
verilog/wb_arbiter.sv
verilog/exe_core.sv
verification/exe_core_sva.sv
verification/exe_core_tb.sv

//--- verification/exe_core_sva.sv
// Execute cluster assertions on issue strobes and unit classes
`timescale 1ns/1ps
`default_nettype none

module exe_core_sva (
  input wire logic                 clk,
  input wire logic                 rst_n,
  input wire logic                 sc0_issue,
  input wire logic                 sc1_issue,
  input wire logic                 mc_issue,
  input wire logic                 sc0_busy,
  input wire logic                 sc1_busy,
  input wire logic                 mc_busy,
  input wire exe_bus_pkg::issue_t  issue
);

  // Station issues at most one instruction per cycle
  one_issue: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({sc0_issue, sc1_issue, mc_issue}))
    else $error("more than one issue strobe high");

  no_busy_issue: assert property (@(posedge clk) disable iff (!rst_n)
    !(sc0_issue && sc0_busy) && !(sc1_issue && sc1_busy) && !(mc_issue && mc_busy))
    else $error("issue strobe sent to a busy unit");

  // Multiply opcodes belong to the multi-cycle unit only
  mul_on_mc: assert property (@(posedge clk) disable iff (!rst_n)
    (sc0_issue || sc1_issue) |->
      (issue.op != exe_isa_pkg::MUL && issue.op != exe_isa_pkg::MULH))
    else $error("multiply opcode sent to a simple ALU");

endmodule

bind exe_core exe_core_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .sc0_issue (sc0_issue),
  .sc1_issue (sc1_issue),
  .mc_issue  (mc_issue),
  .sc0_busy  (sc0_busy),
  .sc1_busy  (sc1_busy),
  .mc_busy   (mc_busy),
  .issue     (issue)
);

`default_nettype wire

//--- verification/exe_core_tb.sv
// Execute cluster testbench: vector-driven dispatch and flush with ROB id result checks
`timescale 1ns/1ps
`default_nettype none

module exe_core_tb;

  localparam int MAX_VEC = 64;

  logic                    clk;
  logic                    rst_n;
  logic                    disp_valid;
  exe_isa_pkg::exe_op_e    disp_op;
  exe_isa_pkg::reg_addr_t  disp_rd;
  exe_isa_pkg::reg_addr_t  disp_rs1;
  exe_isa_pkg::reg_addr_t  disp_rs2;
  logic                    rob_flush;
  logic                    disp_stall;
  exe_bus_pkg::wb_t        wb;

  logic [63:0]             vec_mem [0:MAX_VEC-1];
  int                      nvec;
  int                      limit;
  int                      cycles;
  int                      value_errs;
  int                      proto_errs;
  int                      seed;
  int                      gap;
  logic [3:0]              cmd;
  logic [3:0]              prev_cmd;
  exe_isa_pkg::rob_id_t    next_id;
  exe_isa_pkg::rob_id_t    mon_id;
  logic [127:0]            outst;
  logic [127:0]            doomed;
  logic                    saw_stall;
  exe_isa_pkg::data_t      exp_val [128];
  exe_isa_pkg::reg_addr_t  exp_rd  [128];

  exe_core u_exe_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .disp_valid (disp_valid),
    .disp_op    (disp_op),
    .disp_rd    (disp_rd),
    .disp_rs1   (disp_rs1),
    .disp_rs2   (disp_rs2),
    .rob_flush  (rob_flush),
    .disp_stall (disp_stall),
    .wb         (wb)
  );

  always #4 clk = ~clk;

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic dispatch_line(input logic [63:0] w, input logic to_flush);
    disp_valid = 1'b1;
    disp_op    = exe_isa_pkg::exe_op_e'(w[52:48]);
    disp_rd    = w[47:44];
    disp_rs1   = w[43:40];
    disp_rs2   = w[39:36];
    while (disp_stall)
      @(negedge clk);
    exp_val[next_id] = w[31:0];
    exp_rd[next_id]  = w[47:44];
    doomed[next_id]  = to_flush;
    outst[next_id]   = !to_flush;
    next_id          = next_id + 1'b1;
    @(negedge clk);
    disp_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (outst != '0)
      @(negedge clk);
  endtask

  task automatic pulse_flush();
    rob_flush = 1'b1;
    @(negedge clk);
    rob_flush = 1'b0;
  endtask

  // Broadcast monitor, sampled mid-cycle where wb is stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (disp_stall)
        saw_stall = 1'b1;
      if (wb.valid) begin
        mon_id = wb.rob_id;
        assert (!doomed[mon_id]) else begin
          proto_errs++;
          $display("Flushed ROB id %0d was broadcast at %0t", mon_id, $time);
        end
        assert (outst[mon_id] || doomed[mon_id]) else begin
          proto_errs++;
          $display("ROB id %0d broadcast without an outstanding dispatch at %0t", mon_id, $time);
        end
        if (outst[mon_id]) begin
          assert (wb.result == exp_val[mon_id]) else begin
            value_errs++;
            $display("[ERROR] %0t rob %0d result %h expected %h",
                     $time, mon_id, wb.result, exp_val[mon_id]);
          end
          assert (wb.rd == exp_rd[mon_id]) else begin
            value_errs++;
            $display("[ERROR] %0t rob %0d rd %0d expected %0d",
                     $time, mon_id, wb.rd, exp_rd[mon_id]);
          end
          outst[mon_id] = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    disp_valid = 1'b0;
    disp_op    = exe_isa_pkg::ADD;
    disp_rd    = '0;
    disp_rs1   = '0;
    disp_rs2   = '0;
    rob_flush  = 1'b0;
    seed       = 32'h8841;
    cycles     = 0;
    limit      = 0;
    value_errs = 0;
    proto_errs = 0;
    next_id    = '0;
    outst      = '0;
    doomed     = '0;
    saw_stall  = 1'b0;
    prev_cmd   = '0;

    for (int i = 0; i < MAX_VEC; i++)
      vec_mem[i] = '0;
    $readmemh("verification/exe_core_vectors.txt", vec_mem);
    nvec = 0;
    while (nvec < MAX_VEC && vec_mem[nvec][63:60] != 4'h0)
      nvec++;
    limit = 40 * nvec + 200;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < nvec; i++) begin
      cmd = vec_mem[i][63:60];
      case (cmd)
        4'h1: begin
          gap = $random(seed) & 3;
          repeat (gap) @(negedge clk);
          dispatch_line(vec_mem[i], 1'b0);
        end
        4'h2: dispatch_line(vec_mem[i], 1'b0);
        4'h3: begin
          // Doomed group starts from an idle cluster so nothing of it escapes
          if (prev_cmd != 4'h3)
            wait_drained();
          dispatch_line(vec_mem[i], 1'b1);
        end
        4'h4: pulse_flush();
        default: begin
          proto_errs++;
          $display("Vector line %0d has an unknown command", i);
        end
      endcase
      prev_cmd = cmd;
    end

    wait_drained();
    repeat (10) @(negedge clk);

    assert (saw_stall) else begin
      proto_errs++;
      $display("The station never reported full");
    end

    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/exe_core_vectors.txt
// cmd(1=dispatch after gap, 2=back-to-back, 3=dispatch to be flushed, 4=flush) _ 0 _ op _ rd _ rs1
// _ rs2 _ 0 _ expected result (ROB ids count from zero in line order)
1_0_00_1_2_3_0_05050505
1_0_04_4_5_6_0_03030303
1_0_07_7_0_1_0_00000001
2_0_05_8_9_7_0_12121212
2_0_01_9_8_1_0_0D0D0D0D
1_0_01_A_0_4_0_FCFCFCFD
1_0_18_2_4_4_0_241B1209
2_0_19_3_A_4_0_FFF6EDE4
2_0_00_B_1_4_0_08080808
1_0_03_5_1_0_0_05050505
2_0_02_5_8_6_0_02020202
2_0_00_C_5_5_0_04040404
3_0_18_6_2_2_0_00000000
3_0_00_1_6_6_0_00000000
4_0_00_0_0_0_0_00000000
1_0_06_D_1_7_0_02828282
1_0_00_E_6_3_0_05FCF3EA
1_0_18_2_7_1_0_05050505
2_0_18_3_2_7_0_05050505
2_0_18_4_3_7_0_05050505
2_0_00_8_4_0_0_05050505
2_0_04_9_4_1_0_00000000
2_0_01_A_4_7_0_05050504
2_0_03_B_4_6_0_07070707
2_0_02_C_4_6_0_04040404
2_0_05_D_4_7_0_0A0A0A0A
2_0_06_E_4_7_0_02828282
2_0_07_F_4_0_0_00000000
2_0_00_1_4_4_0_0A0A0A0A

//--- verilog/dispatch_unit.sv
// Dispatch: register read with broadcast bypass, pending-tag rename and ROB id tagging
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      disp_valid,
  input  exe_isa_pkg::exe_op_e      disp_op,
  input  exe_isa_pkg::reg_addr_t    disp_rd,
  input  exe_isa_pkg::reg_addr_t    disp_rs1,
  input  exe_isa_pkg::reg_addr_t    disp_rs2,
  input  logic                      rs_full,
  input  exe_bus_pkg::wb_t          wb,
  input  logic                      rob_flush,
  output logic                      ins_valid,
  output exe_bus_pkg::disp_entry_t  ins_entry
);

  exe_isa_pkg::data_t                  regs     [exe_isa_pkg::NUM_REGS];
  exe_isa_pkg::rob_id_t                pend_tag [exe_isa_pkg::NUM_REGS];
  logic [exe_isa_pkg::NUM_REGS-1:0]    pend;
  exe_isa_pkg::rob_id_t                next_id;
  logic                                accept;
  logic                                wb_write;

  // Returns {ready, value}; a pending source takes a matching broadcast directly
  function automatic logic [exe_isa_pkg::DATA_W:0] read_src(input exe_isa_pkg::reg_addr_t rs);
    if (rs == '0)
      return {1'b1, exe_isa_pkg::data_t'(0)};
    if (!pend[rs])
      return {1'b1, regs[rs]};
    if (wb.valid && wb.rob_id == pend_tag[rs])
      return {1'b1, wb.result};
    return {1'b0, exe_isa_pkg::data_t'(pend_tag[rs])};
  endfunction

  always_comb begin
    accept    = disp_valid && !rs_full && !rob_flush;
    ins_valid = accept;
    // Only the youngest producer of rd may update it
    wb_write  = wb.valid && wb.rd != '0 && pend[wb.rd] && pend_tag[wb.rd] == wb.rob_id;

    ins_entry.op     = disp_op;
    ins_entry.rob_id = next_id;
    ins_entry.rd     = disp_rd;
    {ins_entry.src1_rdy, ins_entry.src1} = read_src(disp_rs1);
    {ins_entry.src2_rdy, ins_entry.src2} = read_src(disp_rs2);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend    <= '0;
      next_id <= '0;
      for (int i = 0; i < exe_isa_pkg::NUM_REGS; i++)
        regs[i] <= exe_isa_pkg::data_t'(i) * exe_isa_pkg::REG_INIT_STEP;
    end else if (rob_flush) begin
      pend <= '0;
    end else begin
      if (wb_write) begin
        regs[wb.rd] <= wb.result;
        pend[wb.rd] <= 1'b0;
      end
      // New producer overrides a same-cycle clear
      if (accept) begin
        next_id <= next_id + 1'b1;
        if (disp_rd != '0)
          pend[disp_rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && disp_rd != '0)
      pend_tag[disp_rd] <= next_id;
  end

endmodule

`default_nettype wire

//--- verilog/exe_bus_pkg.sv
// Execute cluster transport: dispatch entries, issue payloads and writeback broadcast
`default_nettype none

package exe_bus_pkg;

  // Operand value low bits hold the producer ROB id while not ready
  typedef struct packed {
    exe_isa_pkg::exe_op_e   op;
    exe_isa_pkg::rob_id_t   rob_id;
    exe_isa_pkg::reg_addr_t rd;
    logic                   src1_rdy;
    exe_isa_pkg::data_t     src1;
    logic                   src2_rdy;
    exe_isa_pkg::data_t     src2;
  } disp_entry_t;

  typedef struct packed {
    exe_isa_pkg::exe_op_e   op;
    exe_isa_pkg::rob_id_t   rob_id;
    exe_isa_pkg::reg_addr_t rd;
    exe_isa_pkg::data_t     src1;
    exe_isa_pkg::data_t     src2;
  } issue_t;

  typedef struct packed {
    logic                   valid;
    exe_isa_pkg::rob_id_t   rob_id;
    exe_isa_pkg::reg_addr_t rd;
    exe_isa_pkg::data_t     result;
  } wb_t;

endpackage

`default_nettype wire

//--- verilog/exe_core.sv
// Execute cluster top: dispatch, reservation station, three ALUs and writeback arbiter
`timescale 1ns/1ps
`default_nettype none

module exe_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    disp_valid,
  input  exe_isa_pkg::exe_op_e    disp_op,
  input  exe_isa_pkg::reg_addr_t  disp_rd,
  input  exe_isa_pkg::reg_addr_t  disp_rs1,
  input  exe_isa_pkg::reg_addr_t  disp_rs2,
  input  logic                    rob_flush,
  output logic                    disp_stall,
  output exe_bus_pkg::wb_t        wb
);

  logic                      ins_valid;
  exe_bus_pkg::disp_entry_t  ins_entry;
  exe_bus_pkg::issue_t       issue;
  logic                      sc0_issue;
  logic                      sc1_issue;
  logic                      mc_issue;
  logic                      sc0_busy;
  logic                      sc1_busy;
  logic                      mc_busy;
  exe_bus_pkg::wb_t          sc0_result;
  exe_bus_pkg::wb_t          sc1_result;
  exe_bus_pkg::wb_t          mc_result;
  logic                      sc0_grant;
  logic                      sc1_grant;
  logic                      mc_grant;

  dispatch_unit u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .disp_valid (disp_valid),
    .disp_op    (disp_op),
    .disp_rd    (disp_rd),
    .disp_rs1   (disp_rs1),
    .disp_rs2   (disp_rs2),
    .rs_full    (disp_stall),
    .wb         (wb),
    .rob_flush  (rob_flush),
    .ins_valid  (ins_valid),
    .ins_entry  (ins_entry)
  );

  // Station full level is the external stall
  reservation_station u_rs (
    .clk       (clk),
    .rst_n     (rst_n),
    .ins_valid (ins_valid),
    .ins_entry (ins_entry),
    .rs_full   (disp_stall),
    .issue     (issue),
    .sc0_issue (sc0_issue),
    .sc1_issue (sc1_issue),
    .mc_issue  (mc_issue),
    .sc0_busy  (sc0_busy),
    .sc1_busy  (sc1_busy),
    .mc_busy   (mc_busy),
    .wb        (wb),
    .rob_flush (rob_flush)
  );

  sc_alu u_sc0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (sc0_issue),
    .issue     (issue),
    .grant     (sc0_grant),
    .rob_flush (rob_flush),
    .busy      (sc0_busy),
    .result    (sc0_result)
  );

  sc_alu u_sc1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (sc1_issue),
    .issue     (issue),
    .grant     (sc1_grant),
    .rob_flush (rob_flush),
    .busy      (sc1_busy),
    .result    (sc1_result)
  );

  mc_alu u_mc (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (mc_issue),
    .issue     (issue),
    .grant     (mc_grant),
    .rob_flush (rob_flush),
    .busy      (mc_busy),
    .result    (mc_result)
  );

  wb_arbiter u_arb (
    .sc0_result (sc0_result),
    .sc1_result (sc1_result),
    .mc_result  (mc_result),
    .sc0_grant  (sc0_grant),
    .sc1_grant  (sc1_grant),
    .mc_grant   (mc_grant),
    .wb         (wb)
  );

endmodule

`default_nettype wire

//--- verilog/exe_isa_pkg.sv
// Execute cluster ISA: opcode encoding, issue targets, widths and sizing
`default_nettype none

package exe_isa_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 4;
  localparam int NUM_REGS   = 1 << REG_ADDR_W;
  localparam int ROB_ID_W   = 7;
  localparam int RS_ENTRIES = 8;
  localparam int RS_IDX_W   = $clog2(RS_ENTRIES);
  localparam int MC_STAGES  = 3;

  // Register xN leaves reset holding N times this step
  localparam logic [DATA_W-1:0] REG_INIT_STEP = 32'h0101_0101;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [ROB_ID_W-1:0]   rob_id_t;

  // Both top bits set marks a multi-cycle only opcode
  typedef enum logic [4:0] {
    ADD  = 5'h00,
    SUB  = 5'h01,
    AND  = 5'h02,
    OR   = 5'h03,
    XOR  = 5'h04,
    SLL  = 5'h05,
    SRL  = 5'h06,
    SLT  = 5'h07,
    MUL  = 5'h18,
    MULH = 5'h19
  } exe_op_e;

  typedef enum logic [1:0] {
    SC0,
    SC1,
    MC
  } exe_unit_e;

  function automatic logic is_mc_only(input exe_op_e op);
    return &op[4:3];
  endfunction

  // Simple ALU operations, shared by every unit
  function automatic data_t simple_result(input exe_op_e op, input data_t a, input data_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SLT:     return data_t'($signed(a) < $signed(b));
      default: return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- verilog/mc_alu.sv
// Multi-cycle ALU: pipelined execution of every opcode, frozen while its output waits
`timescale 1ns/1ps
`default_nettype none

module mc_alu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  exe_bus_pkg::issue_t  issue,
  input  logic                 grant,
  input  logic                 rob_flush,
  output logic                 busy,
  output exe_bus_pkg::wb_t     result
);

  logic [exe_isa_pkg::MC_STAGES-1:0]     vld;
  exe_bus_pkg::issue_t                   op_q;
  exe_bus_pkg::wb_t                      pipe [1:exe_isa_pkg::MC_STAGES-1];
  logic signed [2*exe_isa_pkg::DATA_W-1:0] prod;
  exe_isa_pkg::data_t                    exec_val;
  logic                                  hold;
  logic                                  take;

  always_comb begin
    // Ungranted last stage stalls the whole pipe
    hold = vld[exe_isa_pkg::MC_STAGES-1] && !grant;
    busy = hold;
    take = start && !hold;

    prod = $signed(op_q.src1) * $signed(op_q.src2);
    case (op_q.op)
      exe_isa_pkg::MUL:  exec_val = prod[exe_isa_pkg::DATA_W-1:0];
      exe_isa_pkg::MULH: exec_val = prod[2*exe_isa_pkg::DATA_W-1:exe_isa_pkg::DATA_W];
      default:           exec_val = exe_isa_pkg::simple_result(op_q.op, op_q.src1, op_q.src2);
    endcase

    result       = pipe[exe_isa_pkg::MC_STAGES-1];
    result.valid = vld[exe_isa_pkg::MC_STAGES-1];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      vld <= '0;
    else if (rob_flush)
      vld <= '0;
    else if (!hold)
      vld <= {vld[exe_isa_pkg::MC_STAGES-2:0], take};
  end

  // Operands in stage 0, computed result moves through the rest
  always_ff @(posedge clk) begin
    if (!hold) begin
      if (take)
        op_q <= issue;
      pipe[1] <= '{valid: 1'b1, rob_id: op_q.rob_id, rd: op_q.rd, result: exec_val};
      for (int k = 2; k < exe_isa_pkg::MC_STAGES; k++)
        pipe[k] <= pipe[k-1];
    end
  end

endmodule

`default_nettype wire

//--- verilog/reservation_station.sv
// Reservation station: operand wake-up from writeback and lowest-ready issue selection
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ins_valid,
  input  exe_bus_pkg::disp_entry_t  ins_entry,
  output logic                      rs_full,
  output exe_bus_pkg::issue_t       issue,
  output logic                      sc0_issue,
  output logic                      sc1_issue,
  output logic                      mc_issue,
  input  logic                      sc0_busy,
  input  logic                      sc1_busy,
  input  logic                      mc_busy,
  input  exe_bus_pkg::wb_t          wb,
  input  logic                      rob_flush
);

  exe_bus_pkg::disp_entry_t             ent [exe_isa_pkg::RS_ENTRIES];
  logic [exe_isa_pkg::RS_ENTRIES-1:0]   vld;
  logic [exe_isa_pkg::RS_ENTRIES-1:0]   rdy;
  logic [exe_isa_pkg::RS_IDX_W-1:0]     ins_idx;
  logic [exe_isa_pkg::RS_IDX_W-1:0]     iss_idx;
  logic                                 insert;
  logic                                 iss_any;
  logic                                 iss_take;
  logic                                 mc_only;
  exe_isa_pkg::exe_unit_e               target;

  // Priority encoder, lowest set bit wins
  function automatic logic [exe_isa_pkg::RS_IDX_W-1:0] lowest_set(
    input logic [exe_isa_pkg::RS_ENTRIES-1:0] vec
  );
    logic [exe_isa_pkg::RS_IDX_W-1:0] idx;
    idx = '0;
    for (int i = exe_isa_pkg::RS_ENTRIES - 1; i >= 0; i--)
      if (vec[i])
        idx = exe_isa_pkg::RS_IDX_W'(i);
    return idx;
  endfunction

  // Capture a broadcast result for any operand still waiting on its tag
  function automatic exe_bus_pkg::disp_entry_t wake(
    input exe_bus_pkg::disp_entry_t e,
    input exe_bus_pkg::wb_t         b
  );
    exe_bus_pkg::disp_entry_t w;
    w = e;
    if (b.valid && !e.src1_rdy && exe_isa_pkg::rob_id_t'(e.src1) == b.rob_id) begin
      w.src1_rdy = 1'b1;
      w.src1     = b.result;
    end
    if (b.valid && !e.src2_rdy && exe_isa_pkg::rob_id_t'(e.src2) == b.rob_id) begin
      w.src2_rdy = 1'b1;
      w.src2     = b.result;
    end
    return w;
  endfunction

  always_comb begin
    for (int i = 0; i < exe_isa_pkg::RS_ENTRIES; i++)
      rdy[i] = vld[i] && ent[i].src1_rdy && ent[i].src2_rdy;

    rs_full = &vld;
    insert  = ins_valid && !rs_full;
    ins_idx = lowest_set(~vld);
    iss_any = |rdy;
    iss_idx = lowest_set(rdy);

    issue.op     = ent[iss_idx].op;
    issue.rob_id = ent[iss_idx].rob_id;
    issue.rd     = ent[iss_idx].rd;
    issue.src1   = ent[iss_idx].src1;
    issue.src2   = ent[iss_idx].src2;

    // First free unit in order SC0, SC1, MC
    mc_only  = exe_isa_pkg::is_mc_only(ent[iss_idx].op);
    target   = exe_isa_pkg::MC;
    iss_take = 1'b0;
    if (iss_any) begin
      if (!mc_only && !sc0_busy) begin
        target   = exe_isa_pkg::SC0;
        iss_take = 1'b1;
      end else if (!mc_only && !sc1_busy) begin
        target   = exe_isa_pkg::SC1;
        iss_take = 1'b1;
      end else if (!mc_busy) begin
        iss_take = 1'b1;
      end
    end

    sc0_issue = iss_take && target == exe_isa_pkg::SC0;
    sc1_issue = iss_take && target == exe_isa_pkg::SC1;
    mc_issue  = iss_take && target == exe_isa_pkg::MC;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (rob_flush) begin
      vld <= '0;
    end else begin
      if (iss_take)
        vld[iss_idx] <= 1'b0;
      if (insert)
        vld[ins_idx] <= 1'b1;
    end
  end

  // Insert sees the same broadcast as the resident entries
  always_ff @(posedge clk) begin
    for (int i = 0; i < exe_isa_pkg::RS_ENTRIES; i++)
      ent[i] <= wake(ent[i], wb);
    if (insert)
      ent[ins_idx] <= wake(ins_entry, wb);
  end

endmodule

`default_nettype wire

//--- verilog/sc_alu.sv
// Single-cycle ALU: result held in a register until granted onto writeback
`timescale 1ns/1ps
`default_nettype none

module sc_alu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  exe_bus_pkg::issue_t  issue,
  input  logic                 grant,
  input  logic                 rob_flush,
  output logic                 busy,
  output exe_bus_pkg::wb_t     result
);

  exe_bus_pkg::wb_t res_q;
  logic             res_vld;
  logic             take;

  always_comb begin
    take         = start && !res_vld;
    busy         = res_vld;
    result       = res_q;
    result.valid = res_vld;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      res_vld <= 1'b0;
    else if (rob_flush)
      res_vld <= 1'b0;
    else if (take)
      res_vld <= 1'b1;
    else if (grant)
      res_vld <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (take)
      res_q <= '{valid:  1'b1,
                 rob_id: issue.rob_id,
                 rd:     issue.rd,
                 result: exe_isa_pkg::simple_result(issue.op, issue.src1, issue.src2)};
  end

endmodule

`default_nettype wire

//--- verilog/wb_arbiter.sv
// Writeback arbiter: fixed priority MC, SC1, SC0 onto the shared broadcast
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
  input  exe_bus_pkg::wb_t  sc0_result,
  input  exe_bus_pkg::wb_t  sc1_result,
  input  exe_bus_pkg::wb_t  mc_result,
  output logic              sc0_grant,
  output logic              sc1_grant,
  output logic              mc_grant,
  output exe_bus_pkg::wb_t  wb
);

  always_comb begin
    // Deepest pipeline first so it stalls least
    mc_grant  = mc_result.valid;
    sc1_grant = sc1_result.valid && !mc_result.valid;
    sc0_grant = sc0_result.valid && !mc_result.valid && !sc1_result.valid;

    if (mc_result.valid)
      wb = mc_result;
    else if (sc1_result.valid)
      wb = sc1_result;
    else
      wb = sc0_result;
  end

endmodule

`default_nettype wire
